// File: verilog/usb_ctrl_pkg.sv
/* shared definitions for the endpoint 0 control logic
   request codes, device states, recipients and descriptor constants */
package usb_ctrl_pkg;

   // values follow the standard bRequest codes where one exists
   typedef enum logic [3:0] {
      GET_STATUS        = 4'd0,
      CLEAR_FEATURE     = 4'd1,
      SET_ADDRESS       = 4'd5,
      GET_DESCRIPTOR    = 4'd6,
      GET_CONFIGURATION = 4'd8,
      SET_CONFIGURATION = 4'd9,
      GET_DESC_DEVICE   = 4'd12,
      GET_DESC_CONFIG   = 4'd13,
      STD_PENDING       = 4'd14,  // standard type seen, bRequest not yet
      UNSUPPORTED       = 4'd15
   } req_e;

   typedef enum logic [1:0] {
      DEFAULT    = 2'd0,
      ADDRESS    = 2'd1,
      CONFIGURED = 2'd2
   } dev_state_e;

   // bmRequestType[1:0]
   typedef enum logic [1:0] {
      DEVICE    = 2'd0,
      INTERFACE = 2'd1,
      ENDPOINT  = 2'd2
   } rec_e;

   localparam logic [6:0]  DEV_DESCR_LEN   = 7'd18;
   localparam logic [6:0]  CONF_DESCR_LEN  = 7'd67;
   localparam logic [3:0]  SETUP_LEN       = 4'd8;

   localparam logic [15:0] VENDOR_ID       = 16'h1209;
   localparam logic [15:0] PRODUCT_ID      = 16'h5bf0;
   localparam logic [7:0]  CTRL_MAX_PACKET = 8'd8;
   localparam logic [7:0]  BULK_MAX_PACKET = 8'd64;

   localparam logic [3:0]  ENDP_BULK       = 4'd1;
   localparam logic [3:0]  ENDP_INT        = 4'd2;  // notification endpoint, IN only

endpackage

// File: verilog/descriptor_rom.sv
`timescale 1ns/1ns
/* descriptor ROM for the CDC-ACM function
   returns one byte of the device or configuration descriptor by index */
module descriptor_rom (
   input  usb_ctrl_pkg::req_e req_i,
   input  logic [6:0]         byte_idx_i,
   output logic [7:0]         desc_byte_o
);

   localparam logic [7:0] DEV_DESCR [18] = '{
      {1'b0, usb_ctrl_pkg::DEV_DESCR_LEN}, 8'h01,  // bLength, DEVICE
      8'h00, 8'h02,                                // bcdUSB 2.00
      8'h02, 8'h00, 8'h00,                         // CDC class, subclass, protocol
      usb_ctrl_pkg::CTRL_MAX_PACKET,
      usb_ctrl_pkg::VENDOR_ID[7:0], usb_ctrl_pkg::VENDOR_ID[15:8],
      usb_ctrl_pkg::PRODUCT_ID[7:0], usb_ctrl_pkg::PRODUCT_ID[15:8],
      8'h00, 8'h01,                                // bcdDevice 1.00
      8'h00, 8'h00, 8'h00,                         // no strings
      8'h01                                        // one configuration
   };

   localparam logic [7:0] CONF_DESCR [67] = '{
      // configuration, two interfaces, bus powered 100 mA
      8'h09, 8'h02, {1'b0, usb_ctrl_pkg::CONF_DESCR_LEN}, 8'h00,
      8'h02, 8'h01, 8'h00, 8'h80, 8'h32,
      // communication interface 0, ACM with AT commands
      8'h09, 8'h04, 8'h00, 8'h00, 8'h01, 8'h02, 8'h02, 8'h01, 8'h00,
      8'h05, 8'h24, 8'h00, 8'h10, 8'h01,  // header, CDC 1.10
      8'h04, 8'h24, 8'h02, 8'h00,         // ACM, no capabilities
      8'h05, 8'h24, 8'h06, 8'h00, 8'h01,  // union, master 0 slave 1
      8'h05, 8'h24, 8'h01, 8'h00, 8'h01,  // call management
      // notification endpoint, interrupt IN, 255 ms
      8'h07, 8'h05, {4'h8, usb_ctrl_pkg::ENDP_INT}, 8'h03, 8'h08, 8'h00, 8'hff,
      // data interface 1
      8'h09, 8'h04, 8'h01, 8'h00, 8'h02, 8'h0a, 8'h00, 8'h00, 8'h00,
      // bulk OUT then bulk IN
      8'h07, 8'h05, {4'h0, usb_ctrl_pkg::ENDP_BULK}, 8'h02,
      usb_ctrl_pkg::BULK_MAX_PACKET, 8'h00, 8'h00,
      8'h07, 8'h05, {4'h8, usb_ctrl_pkg::ENDP_BULK}, 8'h02,
      usb_ctrl_pkg::BULK_MAX_PACKET, 8'h00, 8'h00
   };

   always_comb begin
      desc_byte_o = 8'h00;
      case (req_i)
         usb_ctrl_pkg::GET_DESC_DEVICE:
            if (byte_idx_i < usb_ctrl_pkg::DEV_DESCR_LEN)
               desc_byte_o = DEV_DESCR[byte_idx_i[4:0]];
         usb_ctrl_pkg::GET_DESC_CONFIG:
            if (byte_idx_i < usb_ctrl_pkg::CONF_DESCR_LEN)
               desc_byte_o = CONF_DESCR[byte_idx_i];
         default: begin
            // other requests read nothing from here
         end
      endcase
   end

   // index rests at the length after the last byte went out
   always_comb begin
      if (req_i == usb_ctrl_pkg::GET_DESC_DEVICE)
         a_dev_idx: assert (byte_idx_i <= usb_ctrl_pkg::DEV_DESCR_LEN);
      if (req_i == usb_ctrl_pkg::GET_DESC_CONFIG)
         a_conf_idx: assert (byte_idx_i <= usb_ctrl_pkg::CONF_DESCR_LEN);
   end

endmodule

// File: verilog/device_state_reg.sv
`timescale 1ns/1ns
/* committed device address and state
   updated at the end of the status stage, also drives bulk toggle resets */
module device_state_reg (
   input  logic                     clk_i,
   input  logic                     rstn_i,
   input  logic                     commit_i,
   input  usb_ctrl_pkg::req_e       req_i,
   input  logic [7:0]               wvalue_i,
   input  logic                     endp_in_i,
   output logic [6:0]               addr_o,
   output usb_ctrl_pkg::dev_state_e dev_state_o,
   output logic                     in_toggle_reset_o,
   output logic                     out_toggle_reset_o
);

   logic set_cfg;
   logic clr_halt;

   assign set_cfg  = commit_i && (req_i == usb_ctrl_pkg::SET_CONFIGURATION);
   assign clr_halt = commit_i && (req_i == usb_ctrl_pkg::CLEAR_FEATURE);

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         addr_o             <= 7'd0;
         dev_state_o        <= usb_ctrl_pkg::DEFAULT;
         in_toggle_reset_o  <= 1'b0;
         out_toggle_reset_o <= 1'b0;
      end else begin
         in_toggle_reset_o  <= set_cfg || (clr_halt && endp_in_i);  // one cycle pulses
         out_toggle_reset_o <= set_cfg || (clr_halt && !endp_in_i);
         if (commit_i && req_i == usb_ctrl_pkg::SET_ADDRESS) begin
            addr_o      <= wvalue_i[6:0];
            dev_state_o <= (wvalue_i[6:0] == 7'd0) ? usb_ctrl_pkg::DEFAULT
                                                   : usb_ctrl_pkg::ADDRESS;
         end else if (set_cfg) begin
            dev_state_o <= (wvalue_i == 8'd1) ? usb_ctrl_pkg::CONFIGURED
                                              : usb_ctrl_pkg::ADDRESS;
         end
      end
   end

   // the decoder and the sequencer must agree that the request was valid
   a_commit_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
      commit_i |-> req_i != usb_ctrl_pkg::UNSUPPORTED);

endmodule

// File: verilog/setup_decoder.sv
`timescale 1ns/1ns
/* setup packet decoder, collects the eight SETUP bytes
   and validates each field of the supported standard requests */
module setup_decoder (
   input  logic               clk_i,
   input  logic               rstn_i,
   input  logic               setup_i,
   input  logic               out_ready_i,
   input  logic               out_valid_i,
   input  logic [7:0]         out_data_i,
   output usb_ctrl_pkg::req_e req_o,
   output logic               in_dir_o,
   output logic [6:0]         length_o,
   output logic [7:0]         wvalue_o,
   output logic               endp_in_o,
   output logic               setup_done_o
);

   logic [3:0]         cnt_q, cnt_d;
   usb_ctrl_pkg::req_e req_q, req_d;
   usb_ctrl_pkg::rec_e rec_q, rec_d;
   logic               in_dir_q, in_dir_d;
   logic [6:0]         length_q, length_d;
   logic [7:0]         wvalue_q, wvalue_d;
   logic               endp_in_q, endp_in_d;
   logic               bad;      // current byte fails its check
   logic               endp_ok;  // wIndex names an existing endpoint

   assign endp_ok = out_data_i inside {8'h00, 8'h80, {4'h0, usb_ctrl_pkg::ENDP_BULK},
                                       {4'h8, usb_ctrl_pkg::ENDP_BULK},
                                       {4'h8, usb_ctrl_pkg::ENDP_INT}};

   assign req_o        = req_q;
   assign in_dir_o     = in_dir_q;
   assign length_o     = length_q;
   assign wvalue_o     = wvalue_q;
   assign endp_in_o    = endp_in_q;
   assign setup_done_o = (cnt_q == usb_ctrl_pkg::SETUP_LEN);

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         cnt_q     <= 4'd0;
         req_q     <= usb_ctrl_pkg::UNSUPPORTED;
         rec_q     <= usb_ctrl_pkg::DEVICE;
         in_dir_q  <= 1'b0;
         length_q  <= 7'd0;
         wvalue_q  <= 8'h00;
         endp_in_q <= 1'b0;
      end else if (out_ready_i) begin
         cnt_q     <= cnt_d;
         req_q     <= req_d;
         rec_q     <= rec_d;
         in_dir_q  <= in_dir_d;
         length_q  <= length_d;
         wvalue_q  <= wvalue_d;
         endp_in_q <= endp_in_d;
      end
   end

   always_comb begin
      cnt_d     = cnt_q;
      req_d     = req_q;
      rec_d     = rec_q;
      in_dir_d  = in_dir_q;
      length_d  = length_q;
      wvalue_d  = wvalue_q;
      endp_in_d = endp_in_q;
      bad       = 1'b0;
      if (setup_i) begin
         cnt_d = 4'd0;
         req_d = usb_ctrl_pkg::UNSUPPORTED;  // a short packet stays unsupported
      end else if (out_valid_i) begin
         if (cnt_q != usb_ctrl_pkg::SETUP_LEN)
            cnt_d = cnt_q + 4'd1;
         case (cnt_q)
            4'd0: begin  // bmRequestType, class and vendor types stall
               in_dir_d = out_data_i[7];
               rec_d    = usb_ctrl_pkg::rec_e'(out_data_i[1:0]);
               req_d    = usb_ctrl_pkg::STD_PENDING;
               bad      = (out_data_i[6:2] != 5'd0) || (out_data_i[1:0] == 2'b11);
            end
            4'd1: begin  // bRequest
               req_d = usb_ctrl_pkg::req_e'(out_data_i[3:0]);
               if (req_q != usb_ctrl_pkg::STD_PENDING || out_data_i[7:4] != 4'd0) begin
                  bad = 1'b1;
               end else begin
                  case (out_data_i[3:0])
                     4'd0: bad = !in_dir_q;  // GET_STATUS
                     4'd1: bad = in_dir_q;   // CLEAR_FEATURE
                     4'd5, 4'd9: bad = in_dir_q || rec_q != usb_ctrl_pkg::DEVICE;
                     4'd6, 4'd8: bad = !in_dir_q || rec_q != usb_ctrl_pkg::DEVICE;
                     default: bad = 1'b1;
                  endcase
               end
            end
            4'd2: begin  // wValue low
               wvalue_d = out_data_i;
               case (req_q)
                  usb_ctrl_pkg::CLEAR_FEATURE:  // ENDPOINT_HALT only
                     bad = rec_q != usb_ctrl_pkg::ENDPOINT || out_data_i != 8'h00;
                  usb_ctrl_pkg::SET_ADDRESS: bad = out_data_i[7];
                  usb_ctrl_pkg::SET_CONFIGURATION: bad = out_data_i > 8'd1;
                  default: bad = out_data_i != 8'h00;
               endcase
            end
            4'd3: begin  // wValue high, descriptor type for GET_DESCRIPTOR
               if (req_q != usb_ctrl_pkg::GET_DESCRIPTOR)
                  bad = out_data_i != 8'h00;
               else if (out_data_i == 8'd1)
                  req_d = usb_ctrl_pkg::GET_DESC_DEVICE;
               else if (out_data_i == 8'd2)
                  req_d = usb_ctrl_pkg::GET_DESC_CONFIG;
               else
                  bad = 1'b1;
            end
            4'd4: begin  // wIndex low
               endp_in_d = out_data_i[7];
               case (req_q)
                  usb_ctrl_pkg::GET_STATUS:
                     bad = !((rec_q == usb_ctrl_pkg::DEVICE && out_data_i == 8'h00) ||
                             (rec_q == usb_ctrl_pkg::INTERFACE && out_data_i[7:1] == 7'd0) ||
                             (rec_q == usb_ctrl_pkg::ENDPOINT && endp_ok));
                  usb_ctrl_pkg::CLEAR_FEATURE:
                     bad = rec_q != usb_ctrl_pkg::ENDPOINT || !endp_ok;
                  default: bad = out_data_i != 8'h00;
               endcase
            end
            4'd5: bad = out_data_i != 8'h00;  // wIndex high
            4'd6: begin  // wLength low
               length_d = out_data_i[6:0];
               case (req_q)
                  usb_ctrl_pkg::GET_STATUS: bad = out_data_i != 8'd2;
                  usb_ctrl_pkg::GET_CONFIGURATION: bad = out_data_i != 8'd1;
                  usb_ctrl_pkg::GET_DESC_DEVICE,
                  usb_ctrl_pkg::GET_DESC_CONFIG:
                     if (out_data_i[7])
                        length_d = 7'h7f;
                  default: bad = out_data_i != 8'h00;
               endcase
            end
            4'd7: begin  // wLength high, clamp to the descriptor
               case (req_q)
                  usb_ctrl_pkg::GET_DESC_DEVICE:
                     if (out_data_i != 8'h00 || length_q > usb_ctrl_pkg::DEV_DESCR_LEN)
                        length_d = usb_ctrl_pkg::DEV_DESCR_LEN;
                  usb_ctrl_pkg::GET_DESC_CONFIG:
                     if (out_data_i != 8'h00 || length_q > usb_ctrl_pkg::CONF_DESCR_LEN)
                        length_d = usb_ctrl_pkg::CONF_DESCR_LEN;
                  default: bad = out_data_i != 8'h00;
               endcase
            end
            default: bad = 1'b1;  // ninth byte or later
         endcase
         if (bad)
            req_d = usb_ctrl_pkg::UNSUPPORTED;
      end
   end

   // eight bytes always end in a request the sequencer knows
   a_req_final: assert property (@(posedge clk_i) disable iff (!rstn_i)
      setup_done_o |-> !(req_q inside {usb_ctrl_pkg::STD_PENDING,
                                       usb_ctrl_pkg::GET_DESCRIPTOR}));

endmodule

// File: verilog/ctrl_transfer_fsm.sv
`timescale 1ns/1ns
/* control transfer sequencer for endpoint 0
   steps through setup, data, status and stall stages and counts IN bytes */
module ctrl_transfer_fsm (
   input  logic                     clk_i,
   input  logic                     rstn_i,
   input  logic                     setup_i,
   input  logic                     out_valid_i,
   input  logic                     out_err_i,
   input  logic                     out_ready_i,
   input  logic                     in_req_i,
   input  logic                     in_ready_i,
   input  usb_ctrl_pkg::req_e       req_i,
   input  logic                     in_dir_i,
   input  logic [6:0]               length_i,
   input  logic                     setup_done_i,
   input  logic [7:0]               desc_byte_i,
   input  usb_ctrl_pkg::dev_state_e dev_state_i,
   output logic                     stall_o,
   output logic [7:0]               in_data_o,
   output logic                     in_valid_o,
   output logic                     in_zlp_o,
   output logic [6:0]               byte_idx_o,
   output logic                     commit_o
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SETUP,
      ST_DATA,
      ST_STATUS,
      ST_STALL
   } state_e;

   state_e     state_q, state_d;
   logic [6:0] cnt_q, cnt_d;  // IN data bytes already sent

   assign stall_o    = (state_q == ST_STALL);
   assign byte_idx_o = cnt_q;
   // zlp of a no-data request taken by the host
   assign commit_o   = (state_q == ST_STATUS) && !in_dir_i && in_ready_i &&
                       !setup_i && !out_err_i;

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         state_q <= ST_IDLE;
         cnt_q   <= 7'd0;
      end else if (in_ready_i || out_ready_i) begin  // SIE strobes pace everything
         state_q <= state_d;
         cnt_q   <= cnt_d;
      end
   end

   always_comb begin
      state_d    = state_q;
      cnt_d      = 7'd0;
      in_data_o  = 8'h00;
      in_valid_o = 1'b0;
      in_zlp_o   = 1'b0;
      if (out_err_i) begin
         if (state_q != ST_STALL)
            state_d = ST_IDLE;  // a stall survives until the next SETUP
      end else if (setup_i) begin
         state_d = ST_SETUP;
      end else begin
         case (state_q)
            ST_SETUP: begin
               if (!out_valid_i) begin  // end of the setup packet
                  if (!setup_done_i || req_i == usb_ctrl_pkg::UNSUPPORTED)
                     state_d = ST_STALL;
                  else if (!in_dir_i && length_i == 7'd0)
                     state_d = ST_STATUS;
                  else
                     state_d = ST_DATA;
               end
            end
            ST_DATA: begin
               if (!in_dir_i) begin  // no OUT data stage is supported
                  if (in_req_i)
                     state_d = ST_STALL;
                  else if (!out_valid_i)
                     state_d = ST_STATUS;
               end else begin
                  if (cnt_q == length_i) begin
                     state_d = in_req_i ? ST_STALL : ST_STATUS;  // host wants more
                  end else if (req_i == usb_ctrl_pkg::GET_CONFIGURATION &&
                               dev_state_i == usb_ctrl_pkg::DEFAULT) begin
                     state_d = ST_STALL;
                  end else begin
                     in_valid_o = 1'b1;
                     cnt_d      = in_req_i ? cnt_q + 7'd1 : cnt_q;
                     case (req_i)
                        usb_ctrl_pkg::GET_DESC_DEVICE,
                        usb_ctrl_pkg::GET_DESC_CONFIG:
                           in_data_o = desc_byte_i;
                        usb_ctrl_pkg::GET_CONFIGURATION:
                           in_data_o = {7'd0, dev_state_i == usb_ctrl_pkg::CONFIGURED};
                        default:
                           in_data_o = 8'h00;  // GET_STATUS
                     endcase
                  end
                  if (out_valid_i)
                     state_d = ST_STALL;
               end
            end
            ST_STATUS: begin
               if (!in_dir_i) begin
                  in_zlp_o   = 1'b1;
                  in_valid_o = 1'b1;
               end
               state_d = ST_IDLE;
            end
            default: begin
               // idle and stall wait for SETUP
            end
         endcase
      end
   end

   // IN data only for a request the decoder accepted
   a_in_data_request: assert property (@(posedge clk_i) disable iff (!rstn_i)
      (in_valid_o && !in_zlp_o) |-> req_i inside {usb_ctrl_pkg::GET_STATUS,
         usb_ctrl_pkg::GET_CONFIGURATION, usb_ctrl_pkg::GET_DESC_DEVICE,
         usb_ctrl_pkg::GET_DESC_CONFIG});

endmodule

// File: verilog/ctrl_endp.sv
`timescale 1ns/1ns
/* USB full-speed control endpoint 0 for a CDC-ACM device */
module ctrl_endp (
   input  logic       clk_i,
   input  logic       rstn_i,
   input  logic       setup_i,
   input  logic [7:0] out_data_i,
   input  logic       out_valid_i,
   input  logic       out_err_i,
   input  logic       out_ready_i,
   input  logic       in_req_i,
   input  logic       in_ready_i,
   output logic [6:0] addr_o,
   output logic       stall_o,
   output logic [7:0] in_data_o,
   output logic       in_valid_o,
   output logic       in_zlp_o,
   output logic       in_toggle_reset_o,
   output logic       out_toggle_reset_o
);

   usb_ctrl_pkg::req_e       req;
   usb_ctrl_pkg::dev_state_e dev_state;
   logic                     in_dir, endp_in, setup_done, commit;
   logic [6:0]               length, byte_idx;
   logic [7:0]               wvalue, desc_byte;

   setup_decoder setup_decoder_i (
      .clk_i, .rstn_i, .setup_i, .out_ready_i, .out_valid_i, .out_data_i,
      .req_o(req), .in_dir_o(in_dir), .length_o(length), .wvalue_o(wvalue),
      .endp_in_o(endp_in), .setup_done_o(setup_done));

   ctrl_transfer_fsm ctrl_transfer_fsm_i (
      .clk_i, .rstn_i, .setup_i, .out_valid_i, .out_err_i, .out_ready_i,
      .in_req_i, .in_ready_i, .req_i(req), .in_dir_i(in_dir), .length_i(length),
      .setup_done_i(setup_done), .desc_byte_i(desc_byte), .dev_state_i(dev_state),
      .stall_o, .in_data_o, .in_valid_o, .in_zlp_o, .byte_idx_o(byte_idx),
      .commit_o(commit));

   descriptor_rom descriptor_rom_i (
      .req_i(req), .byte_idx_i(byte_idx), .desc_byte_o(desc_byte));

   device_state_reg device_state_reg_i (
      .clk_i, .rstn_i, .commit_i(commit), .req_i(req), .wvalue_i(wvalue),
      .endp_in_i(endp_in), .addr_o, .dev_state_o(dev_state),
      .in_toggle_reset_o, .out_toggle_reset_o);

endmodule

// File: verification/usb_host_tasks.svh
/* host-side SIE model for endpoint 0
   SETUP, IN data and status stages, every wait bounded by WAIT_CYCLES */
`ifndef USB_HOST_TASKS_SVH
`define USB_HOST_TASKS_SVH

// OUT token end, the SIE has no more bytes for this transaction
task end_out_transaction;
   @(posedge clk_i);
   out_valid_i <= 1'b0;
   out_ready_i <= 1'b1;
   @(posedge clk_i);
   out_ready_i <= 1'b0;
   @(negedge clk_i);
endtask

task pulse_in_ready;
   @(posedge clk_i);
   in_ready_i <= 1'b1;
   @(posedge clk_i);
   in_ready_i <= 1'b0;
   @(negedge clk_i);
endtask

// SETUP token, then nbytes of sb, then the end of the packet
task send_setup(input int nbytes);
   @(posedge clk_i);
   setup_i     <= 1'b1;
   out_ready_i <= 1'b1;
   @(posedge clk_i);
   setup_i     <= 1'b0;
   out_ready_i <= 1'b0;
   @(negedge clk_i);
   check_value("stall after SETUP", 0, stall_o);  // a new SETUP clears any stall
   for (int i = 0; i < nbytes; i++) begin
      @(posedge clk_i);
      out_valid_i <= 1'b1;
      out_data_i  <= sb[i];
      out_ready_i <= 1'b1;
      @(posedge clk_i);
      out_ready_i <= 1'b0;
   end
   end_out_transaction();
endtask

// collect IN bytes until the endpoint has nothing more to send
task read_in_data;
   int n;
   rx_count = 0;
   rx_sum   = 0;
   n        = 0;
   @(posedge clk_i);
   in_req_i <= 1'b1;
   @(negedge clk_i);
   while (!in_valid_o && n < WAIT_CYCLES) begin
      @(negedge clk_i);
      n++;
   end
   if (!in_valid_o)
      note_timeout("IN data");
   while (in_valid_o && rx_count < 128) begin
      rx[rx_count] = in_data_o;
      rx_sum       = rx_sum + int'(in_data_o);
      rx_count++;
      pulse_in_ready();
   end
   @(posedge clk_i);
   in_req_i <= 1'b0;
endtask

// status stage of a no-data request, host reads the zero-length packet
task send_status_zlp;
   int n;
   n = 0;
   @(posedge clk_i);
   in_req_i <= 1'b1;
   @(negedge clk_i);
   while (!in_zlp_o && n < WAIT_CYCLES) begin
      @(negedge clk_i);
      n++;
   end
   if (!in_zlp_o)
      note_timeout("status zero-length packet");
   else
      pulse_in_ready();
   @(posedge clk_i);
   in_req_i <= 1'b0;
   @(negedge clk_i);
endtask

task wait_stall;
   int n;
   n = 0;
   while (!stall_o && n < WAIT_CYCLES) begin
      @(negedge clk_i);
      n++;
   end
   if (!stall_o)
      note_timeout("stall_o");
endtask

// GET_CONFIGURATION, returns the single data byte
task query_config(output logic [7:0] value);
   sb = '{8'h80, 8'h08, 8'h00, 8'h00, 8'h00, 8'h00, 8'h01, 8'h00};
   send_setup(8);
   read_in_data();
   end_out_transaction();  // status OUT of the IN request
   value = rx[0];
endtask

`endif

// File: verification/tb_ctrl_endp.sv
`timescale 1ns/1ns
/* testbench for the endpoint 0 control logic
   replays control transfers from a data file and checks the replies */
module tb_ctrl_endp;

   localparam int WAIT_CYCLES = 20;

   logic             clk_i;
   logic             rstn_i;
   logic             setup_i, out_valid_i, out_err_i, out_ready_i, in_req_i, in_ready_i;
   logic [7:0]       out_data_i;
   logic [6:0]       addr_o;
   logic [7:0]       in_data_o;
   logic             stall_o, in_valid_o, in_zlp_o, in_toggle_reset_o, out_toggle_reset_o;

   logic [8*24-1:0]  test_name;
   logic [8*8-1:0]   outcome;     // stall, data or nodata
   logic [8*128-1:0] line;
   logic [7:0]       sb [8];      // setup bytes of the current transfer
   logic [7:0]       rx [128];    // IN bytes received
   int               rx_count, rx_sum;
   int               errors = 0;
   int               failures = 0;
   int               tests_run = 0;
   int               in_pulses = 0;
   int               out_pulses = 0;
   int               cur_addr = 0;
   logic             timed_out = 1'b0;

   ctrl_endp ctrl_endp_i (.*);

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   // one count per cycle that a toggle reset is high
   always @(posedge clk_i) begin
      if (in_toggle_reset_o)
         in_pulses <= in_pulses + 1;
      if (out_toggle_reset_o)
         out_pulses <= out_pulses + 1;
   end

   task check_value(input logic [8*24-1:0] what, input int expected, input int actual);
      if (expected != actual) begin
         errors++;
         $display("error %0s %0s expected %0h actual %0h", test_name, what, expected, actual);
      end
   endtask

   task note_timeout(input logic [8*32-1:0] what);
      failures++;
      timed_out = 1'b1;
      $display("timeout while waiting for %0s in test %0s", what, test_name);
   endtask

   `include "usb_host_tasks.svh"

   task run_transfer(input int nbytes, input int exp_count, input int exp_sum,
                     input int exp_addr, input int exp_cfg);
      int         in_base, out_base;
      logic       exp_in, exp_out, dev_desc;
      logic [7:0] cfg;
      exp_in  = 1'b0;
      exp_out = 1'b0;
      if (outcome == "nodata" && sb[1] == 8'h09) begin  // SET_CONFIGURATION resets both
         exp_in  = 1'b1;
         exp_out = 1'b1;
      end else if (outcome == "nodata" && sb[1] == 8'h01) begin
         exp_in  = sb[4][7];  // direction bit of the endpoint
         exp_out = !sb[4][7];
      end
      dev_desc = (sb[1] == 8'h06) && (sb[3] == 8'h01);
      in_base  = in_pulses;
      out_base = out_pulses;
      rx_count = 0;
      rx_sum   = 0;
      send_setup(nbytes);
      if (outcome == "stall") begin
         wait_stall();
      end else if (outcome == "data") begin
         read_in_data();
         end_out_transaction();
      end else if (outcome == "nodata") begin
         check_value("addr before status", cur_addr, addr_o);
         send_status_zlp();
      end else begin
         failures++;
         $display("test %0s has an unknown outcome %0s", test_name, outcome);
      end
      if (!timed_out) begin
         check_value("IN byte count", exp_count, rx_count);
         check_value("IN byte sum", exp_sum, rx_sum);
         if (dev_desc && rx_count > 1) begin
            check_value("descriptor byte 0", 8'h12, rx[0]);
            check_value("descriptor byte 1", 8'h01, rx[1]);
         end
         check_value("in toggle resets", exp_in, in_pulses - in_base);
         check_value("out toggle resets", exp_out, out_pulses - out_base);
         check_value("address", exp_addr, addr_o);
         if (exp_addr != 0) begin  // Default state would stall the query
            query_config(cfg);
            check_value("configuration", exp_cfg, cfg);
         end
      end
      cur_addr = exp_addr;
   endtask

   initial begin
      int   fd, code, nbytes, exp_count, exp_sum, exp_addr, exp_cfg;
      logic stop;
      rstn_i      = 1'b0;
      setup_i     = 1'b0;
      out_data_i  = 8'h00;
      out_valid_i = 1'b0;
      out_err_i   = 1'b0;
      out_ready_i = 1'b0;
      in_req_i    = 1'b0;
      in_ready_i  = 1'b0;
      stop        = 1'b0;
      repeat (3) @(posedge clk_i);
      rstn_i <= 1'b1;
      @(negedge clk_i);
      test_name = "reset";
      check_value("stall_o", 0, stall_o);
      check_value("in_valid_o", 0, in_valid_o);
      check_value("zlp and toggles", 0, {in_zlp_o, in_toggle_reset_o, out_toggle_reset_o});
      check_value("address", 0, addr_o);
      fd = $fopen("verification/ctrl_tests.dat", "r");
      if (fd == 0) begin
         $display("cannot open verification/ctrl_tests.dat");
         failures++;
         stop = 1'b1;
      end
      while (!stop) begin
         code = $fscanf(fd, "%s", test_name);
         if (code != 1) begin
            stop = 1'b1;
         end else if (test_name == "#") begin
            code = $fgets(line, fd);  // comment line
         end else begin
            code = $fscanf(fd, "%d %h %h %h %h %h %h %h %h %s %d %h %h %h", nbytes,
                           sb[0], sb[1], sb[2], sb[3], sb[4], sb[5], sb[6], sb[7],
                           outcome, exp_count, exp_sum, exp_addr, exp_cfg);
            if (code != 14) begin
               $display("malformed line in the test file at test %0s", test_name);
               failures++;
               stop = 1'b1;
            end else begin
               tests_run++;
               run_transfer(nbytes, exp_count, exp_sum, exp_addr, exp_cfg);
               stop = timed_out;
            end
         end
      end
      if (fd != 0)
         $fclose(fd);
      if (tests_run == 0) begin
         $display("no test was run");
         failures++;
      end
      $display("tests %0d, value errors %0d, other failures %0d", tests_run, errors, failures);
      if (errors == 0 && failures == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// File: verification/ctrl_tests.dat
# name nbytes setup0..setup7(hex) outcome in_count in_sum(hex) addr(hex) cfg(hex)
# outcome is stall, data or nodata; addr and cfg are the values after the transfer
get_dev_desc_64 8 80 06 00 01 00 00 40 00 data 18 187 0 0
get_dev_desc_8 8 80 06 00 01 00 00 08 00 data 8 1f 0 0
get_conf_desc_9 8 80 06 00 02 00 00 09 00 data 9 103 0 0
get_conf_desc_255 8 80 06 00 02 00 00 ff 00 data 67 4a5 0 0
get_status_dev 8 80 00 00 00 00 00 02 00 data 2 0 0 0
set_address_5 8 00 05 05 00 00 00 00 00 nodata 0 0 5 0
get_config_addr 8 80 08 00 00 00 00 01 00 data 1 0 5 0
set_config_1 8 00 09 01 00 00 00 00 00 nodata 0 0 5 1
get_config_conf 8 80 08 00 00 00 00 01 00 data 1 1 5 1
clear_halt_ep81 8 02 01 00 00 81 00 00 00 nodata 0 0 5 1
clear_halt_ep01 8 02 01 00 00 01 00 00 00 nodata 0 0 5 1
get_status_ep81 8 82 00 00 00 81 00 02 00 data 2 0 5 1
class_line_coding 8 21 20 00 00 00 00 07 00 stall 0 0 5 1
set_config_2 8 00 09 02 00 00 00 00 00 stall 0 0 5 1
get_interface 8 81 0a 00 00 00 00 01 00 stall 0 0 5 1
setup_cut_6 6 80 06 00 01 00 00 40 00 stall 0 0 5 1
get_dev_desc_again 8 80 06 00 01 00 00 40 00 data 18 187 5 1
set_config_0 8 00 09 00 00 00 00 00 00 nodata 0 0 5 0

// File: verilog.f
+incdir+verification
verilog/usb_ctrl_pkg.sv
verilog/descriptor_rom.sv
verilog/device_state_reg.sv
verilog/setup_decoder.sv
verilog/ctrl_transfer_fsm.sv
verilog/ctrl_endp.sv
verification/tb_ctrl_endp.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the endpoint 0 testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_ctrl_endp
out=$(./obj_dir/Vtb_ctrl_endp)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "PASS: all tests"
